//--- common/udp_defs.svh
`ifndef UDP_DEFS_SVH
`define UDP_DEFS_SVH

// ----------------------------------------------------------------------
// datagram geometry
// ----------------------------------------------------------------------

// UDP header, source port + destination port + length + checksum
`define UDP_HDR_LEN 8

// ----------------------------------------------------------------------
// buffer sizing
// ----------------------------------------------------------------------

// payload bytes held by the store-and-forward buffer
`define UDP_FIFO_DEPTH 256

// committed datagrams waiting for the framer
`define UDP_META_DEPTH 4

`endif

//--- common/udp_pkg.sv
`default_nettype none

`include "udp_defs.svh"

package udp_pkg;

  // ----------------------------------------------------------------------
  // basic field types
  // ----------------------------------------------------------------------

  typedef logic [7:0] byte_t;

  typedef logic [15:0] port_t;

  // length field of the UDP header, header bytes included
  typedef logic [15:0] udp_len_t;

  localparam int FIFO_AW = $clog2(`UDP_FIFO_DEPTH);

  // the extra top bit tells a full buffer from an empty one
  typedef logic [FIFO_AW:0] fifo_ptr_t;

  // ----------------------------------------------------------------------
  // datagram metadata
  // ----------------------------------------------------------------------

  typedef struct packed {
    port_t    src_port;
    udp_len_t len;
  } udp_meta_t;

  // ----------------------------------------------------------------------
  // state machines
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    RX_HDR,
    RX_PAYLOAD,
    RX_DROP
  } rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_PAYLOAD
  } tx_state_t;

endpackage

`default_nettype wire

//--- common/udp_payload_if.sv
`default_nettype none

interface udp_payload_if import udp_pkg::*; ();

  // payload byte stream
  byte_t     data;
  logic      last;
  logic      valid;
  logic      ready;

  // datagram close on the write side, one cycle each
  logic      commit;
  logic      drop;

  // on the write side meta_ready means a metadata slot is free
  udp_meta_t meta;
  logic      meta_valid;
  logic      meta_ready;

  modport wr_src (
    output data, valid, commit, drop, meta,
    input  ready, meta_ready
  );

  modport wr_dst (
    input  data, valid, commit, drop, meta,
    output ready, meta_ready
  );

  modport rd_src (
    output data, valid, last, meta, meta_valid,
    input  ready, meta_ready
  );

  modport rd_dst (
    input  data, valid, last, meta, meta_valid,
    output ready, meta_ready
  );

endinterface

`default_nettype wire

//--- udp_rx/udp_rx_parser.sv
`default_nettype none

`include "udp_defs.svh"

module udp_rx_parser import udp_pkg::*; (
  input  logic          clk,
  input  logic          fsm_rst,
  input  port_t         local_port,
  input  byte_t         rx_data,
  input  logic          rx_valid,
  output logic          rx_ready,
  input  logic          rx_sof,
  input  logic          rx_eof,
  udp_payload_if.wr_src wr,
  output logic [15:0]   drop_count
);

  rx_state_t                     state;
  udp_len_t                      byte_cnt;
  udp_len_t                      cnt_nxt;
  udp_len_t                      hdr_len;
  udp_len_t                      len_nxt;
  port_t                         dst_nxt;
  logic [`UDP_HDR_LEN-1:0][7:0]  hdr_q;
  logic [`UDP_HDR_LEN-1:0][7:0]  hdr_nxt;
  logic                          beat;
  logic                          hdr_ok;
  logic                          commit_q;
  logic                          drop_q;

  // ----------------------------------------------------------------------
  // header view and checks
  // ----------------------------------------------------------------------

  assign beat    = rx_valid && rx_ready;
  assign cnt_nxt = (rx_sof ? '0 : byte_cnt) + 1'b1;

  // newest byte enters at index 0, so the first byte ends up at the top
  assign hdr_nxt = {hdr_q[`UDP_HDR_LEN-2:0], rx_data};
  assign dst_nxt = hdr_nxt[5:4];
  assign len_nxt = hdr_nxt[3:2];
  assign hdr_len = hdr_q[3:2];

  assign hdr_ok = (dst_nxt == local_port) &&
                  (len_nxt >= udp_len_t'(`UDP_HDR_LEN)) &&
                  (len_nxt <= udp_len_t'(`UDP_HDR_LEN + `UDP_FIFO_DEPTH));

  // ----------------------------------------------------------------------
  // stream side
  // ----------------------------------------------------------------------

  always_comb begin
    case (state)
      // a new datagram only starts once its metadata has somewhere to go
      RX_HDR:     rx_ready = (byte_cnt != '0) || wr.meta_ready;
      RX_PAYLOAD: rx_ready = wr.ready;
      default:    rx_ready = 1'b1;
    endcase
  end

  assign wr.data          = rx_data;
  assign wr.valid         = (state == RX_PAYLOAD) && rx_valid;
  assign wr.commit        = commit_q;
  assign wr.drop          = drop_q;
  assign wr.meta.src_port = hdr_q[7:6];
  assign wr.meta.len      = hdr_len;

  always_ff @(posedge clk) begin
    if (beat && state == RX_HDR) begin
      hdr_q <= hdr_nxt;
    end
  end

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state      <= RX_HDR;
      byte_cnt   <= '0;
      commit_q   <= 1'b0;
      drop_q     <= 1'b0;
      drop_count <= '0;
    end else begin
      commit_q <= 1'b0;
      drop_q   <= 1'b0;
      if (drop_q) begin
        drop_count <= drop_count + 1'b1;
      end
      if (beat) begin
        byte_cnt <= cnt_nxt;
        case (state)
          RX_HDR: begin
            if (rx_eof) begin
              byte_cnt <= '0;
              // ending right after the header is only fine when length says 8
              if (cnt_nxt == udp_len_t'(`UDP_HDR_LEN) && hdr_ok &&
                  len_nxt == udp_len_t'(`UDP_HDR_LEN)) begin
                commit_q <= 1'b1;
              end else begin
                drop_q <= 1'b1;
              end
            end else if (cnt_nxt == udp_len_t'(`UDP_HDR_LEN)) begin
              if (hdr_ok && len_nxt != udp_len_t'(`UDP_HDR_LEN)) begin
                state <= RX_PAYLOAD;
              end else begin
                state <= RX_DROP;
              end
            end
          end
          RX_PAYLOAD: begin
            if (rx_eof) begin
              byte_cnt <= '0;
              state    <= RX_HDR;
              if (cnt_nxt == hdr_len) begin
                commit_q <= 1'b1;
              end else begin
                drop_q <= 1'b1;
              end
            end else if (cnt_nxt == hdr_len) begin
              // the length field runs out before eof and the rest is dropped
              state <= RX_DROP;
            end
          end
          default: begin
            if (rx_eof) begin
              byte_cnt <= '0;
              state    <= RX_HDR;
              drop_q   <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  a_commit_drop_excl: assert property (@(posedge clk) disable iff (fsm_rst)
    !(wr.commit && wr.drop));

  // header bytes never reach the buffer
  a_no_write_in_hdr: assert property (@(posedge clk) disable iff (fsm_rst)
    wr.valid |-> byte_cnt >= udp_len_t'(`UDP_HDR_LEN));

endmodule

`default_nettype wire

//--- design/udp_payload_fifo.sv
`default_nettype none

`include "udp_defs.svh"

module udp_payload_fifo import udp_pkg::*; (
  input  logic          clk,
  input  logic          fsm_rst,
  udp_payload_if.wr_dst wr,
  udp_payload_if.rd_src rd
);

  localparam int MAW = $clog2(`UDP_META_DEPTH);

  byte_t        mem [`UDP_FIFO_DEPTH];
  fifo_ptr_t    spec_ptr;
  fifo_ptr_t    cmt_ptr;
  fifo_ptr_t    rd_ptr;
  logic         full;
  logic         wr_push;
  logic         rd_pop;
  logic         meta_pop;

  udp_meta_t    meta_mem [`UDP_META_DEPTH];
  fifo_ptr_t    last_mem [`UDP_META_DEPTH];
  logic [MAW:0] mq_wr;
  logic [MAW:0] mq_rd;
  logic [MAW:0] mq_last;
  logic [MAW:0] mq_used;

  // ----------------------------------------------------------------------
  // write side
  // ----------------------------------------------------------------------

  assign full = (spec_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                (spec_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  assign wr.ready   = !full;
  assign wr_push    = wr.valid && !full;

  // an entry stays taken until the last byte of its datagram is read
  assign mq_used       = mq_wr - mq_last;
  assign wr.meta_ready = (int'(mq_used) + int'(wr.commit)) < `UDP_META_DEPTH;

  always_ff @(posedge clk) begin
    if (wr_push) begin
      mem[spec_ptr[FIFO_AW-1:0]] <= wr.data;
    end
    if (wr.commit) begin
      meta_mem[mq_wr[MAW-1:0]] <= wr.meta;
      last_mem[mq_wr[MAW-1:0]] <= spec_ptr - 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------

  assign rd.valid      = rd_ptr != cmt_ptr;
  assign rd.data       = mem[rd_ptr[FIFO_AW-1:0]];
  assign rd.last       = rd_ptr == last_mem[mq_last[MAW-1:0]];
  assign rd.meta       = meta_mem[mq_rd[MAW-1:0]];
  assign rd.meta_valid = mq_rd != mq_wr;
  assign rd_pop        = rd.valid && rd.ready;
  assign meta_pop      = rd.meta_valid && rd.meta_ready;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      spec_ptr <= '0;
      cmt_ptr  <= '0;
      rd_ptr   <= '0;
      mq_wr    <= '0;
      mq_rd    <= '0;
      mq_last  <= '0;
    end else begin
      if (wr.drop) begin
        spec_ptr <= cmt_ptr;
      end else if (wr_push) begin
        spec_ptr <= spec_ptr + 1'b1;
      end
      if (wr.commit) begin
        cmt_ptr <= spec_ptr;
        mq_wr   <= mq_wr + 1'b1;
      end
      if (meta_pop) begin
        mq_rd <= mq_rd + 1'b1;
      end
      if (rd_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // a header-only datagram has no last byte and frees its entry at pop
      if ((rd_pop && rd.last) ||
          (meta_pop && rd.meta.len == udp_len_t'(`UDP_HDR_LEN))) begin
        mq_last <= mq_last + 1'b1;
      end
    end
  end

  // occupancy never passes the depth
  a_no_write_full: assert property (@(posedge clk) disable iff (fsm_rst)
    (spec_ptr - rd_ptr) <= fifo_ptr_t'(`UDP_FIFO_DEPTH));

  a_no_meta_overflow: assert property (@(posedge clk) disable iff (fsm_rst)
    wr.commit |-> mq_used < (MAW+1)'(`UDP_META_DEPTH));

endmodule

`default_nettype wire

//--- udp_tx/udp_tx_framer.sv
`default_nettype none

`include "udp_defs.svh"

module udp_tx_framer import udp_pkg::*; (
  input  logic          clk,
  input  logic          fsm_rst,
  input  port_t         local_port,
  udp_payload_if.rd_dst rd,
  output byte_t         tx_data,
  output logic          tx_valid,
  input  logic          tx_ready,
  output logic          tx_sof,
  output logic          tx_eof
);

  localparam int HDR_CW = $clog2(`UDP_HDR_LEN);

  tx_state_t                    state;
  logic [`UDP_HDR_LEN-1:0][7:0] hdr_q;
  logic [HDR_CW-1:0]            hdr_cnt;
  logic                         hdr_last;
  logic                         zero_pl;

  assign hdr_last      = hdr_cnt == HDR_CW'(`UDP_HDR_LEN - 1);
  assign rd.meta_ready = state == TX_IDLE;
  assign rd.ready      = (state == TX_PAYLOAD) && tx_ready;

  // ----------------------------------------------------------------------
  // output mux
  // ----------------------------------------------------------------------

  always_comb begin
    tx_valid = 1'b0;
    tx_data  = hdr_q[`UDP_HDR_LEN-1];
    tx_sof   = 1'b0;
    tx_eof   = 1'b0;
    case (state)
      TX_HDR: begin
        tx_valid = 1'b1;
        tx_sof   = hdr_cnt == '0;
        tx_eof   = hdr_last && zero_pl;
      end
      TX_PAYLOAD: begin
        // payload is already committed so it streams without gaps
        tx_valid = rd.valid;
        tx_data  = rd.data;
        tx_eof   = rd.last;
      end
      default: begin
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= TX_IDLE;
      hdr_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (rd.meta_valid) begin
            state   <= TX_HDR;
            hdr_cnt <= '0;
          end
        end
        TX_HDR: begin
          if (tx_ready) begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_last) begin
              state <= zero_pl ? TX_IDLE : TX_PAYLOAD;
            end
          end
        end
        default: begin
          if (rd.valid && tx_ready && rd.last) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

  // reply swaps the ports, keeps the length and sends a zero checksum
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && rd.meta_valid) begin
      hdr_q   <= {local_port, rd.meta.src_port, rd.meta.len, 16'h0000};
      zero_pl <= rd.meta.len == udp_len_t'(`UDP_HDR_LEN);
    end else if (state == TX_HDR && tx_ready) begin
      hdr_q <= hdr_q << 8;
    end
  end

  a_tx_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    (tx_valid && !tx_ready) |=> $stable(tx_data));

endmodule

`default_nettype wire

//--- design/udp_echo_top.sv
`default_nettype none

module udp_echo_top import udp_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  port_t       local_port,

  input  byte_t       rx_data,
  input  logic        rx_valid,
  output logic        rx_ready,
  input  logic        rx_sof,
  input  logic        rx_eof,

  output byte_t       tx_data,
  output logic        tx_valid,
  input  logic        tx_ready,
  output logic        tx_sof,
  output logic        tx_eof,

  output logic [15:0] drop_count
);

  // parser to buffer, and buffer to framer
  udp_payload_if rx_if ();
  udp_payload_if tx_if ();

  udp_rx_parser rx_parser_i (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .local_port (local_port),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .rx_sof     (rx_sof),
    .rx_eof     (rx_eof),
    .wr         (rx_if.wr_src),
    .drop_count (drop_count)
  );

  udp_payload_fifo payload_fifo_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr      (rx_if.wr_dst),
    .rd      (tx_if.rd_src)
  );

  udp_tx_framer tx_framer_i (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .local_port (local_port),
    .rd         (tx_if.rd_dst),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .tx_sof     (tx_sof),
    .tx_eof     (tx_eof)
  );

endmodule

`default_nettype wire

//--- bench/udp_echo_tb.sv
`default_nettype none

`include "udp_defs.svh"

module udp_echo_tb import udp_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int KIND_GOOD     = 0;
  localparam int KIND_BAD_PORT = 1;
  localparam int KIND_BAD_LEN  = 2;
  localparam int KIND_OVER_LEN = 3;
  localparam int KIND_SHORT    = 4;

  localparam int RX_TIMEOUT    = 4000;
  localparam int REPLY_TIMEOUT = 8000;
  localparam int DROP_TIMEOUT  = 50;

  logic        clk;
  logic        fsm_rst;
  port_t       local_port;
  byte_t       rx_data;
  logic        rx_valid;
  logic        rx_ready;
  logic        rx_sof;
  logic        rx_eof;
  byte_t       tx_data;
  logic        tx_valid;
  logic        tx_ready;
  logic        tx_sof;
  logic        tx_eof;
  logic [15:0] drop_count;

  integer      seed = 40181;
  integer      stall_seed = 40181 + 7;
  int          stall_pct;
  int          rx_stalls;
  logic [15:0] drop_exp;

  // expected reply beats packed as {sof, eof, data}
  logic [9:0]  exp_q [$];
  logic [9:0]  exp_beat;
  logic [7:0]  frame_q [$];
  logic [7:0]  pay_q [$];

  logic        held;
  logic [7:0]  held_data;
  logic        held_sof;
  logic        held_eof;

  udp_echo_top dut_i (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .local_port (local_port),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .rx_sof     (rx_sof),
    .rx_eof     (rx_eof),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .tx_sof     (tx_sof),
    .tx_eof     (tx_eof),
    .drop_count (drop_count)
  );

  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // checking and failure
  // ----------------------------------------------------------------------

  task automatic fail_now(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s actual 0x%0h expected 0x%0h",
               $time, name, actual, expected);
      fail_now("output value differs from the reference model");
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  function automatic int ready_roll();
    logic [31:0] r;
    r = $random(stall_seed);
    return int'(r % 32'd100);
  endfunction

  // ----------------------------------------------------------------------
  // tx monitor that drives tx_ready and checks every accepted beat
  // ----------------------------------------------------------------------

  // outputs come from registers only, so the falling edge sees them settled
  always @(negedge clk) begin
    if (fsm_rst) begin
      tx_ready = 1'b1;
      held     = 1'b0;
    end else begin
      if (held) begin
        check_value("tx_valid (stalled)", 32'(tx_valid), 32'd1);
        check_value("tx_data (stalled)", 32'(tx_data), 32'(held_data));
        check_value("tx_sof (stalled)", 32'(tx_sof), 32'(held_sof));
        check_value("tx_eof (stalled)", 32'(tx_eof), 32'(held_eof));
      end
      tx_ready = ready_roll() >= stall_pct;
      if (tx_valid && tx_ready) begin
        if (exp_q.size() == 0) begin
          fail_now("tx beat arrived while no reply was expected");
        end else begin
          exp_beat = exp_q.pop_front();
          check_value("tx_data", 32'(tx_data), 32'(exp_beat[7:0]));
          check_value("tx_sof", 32'(tx_sof), 32'(exp_beat[9]));
          check_value("tx_eof", 32'(tx_eof), 32'(exp_beat[8]));
        end
      end
      held      = tx_valid && !tx_ready;
      held_data = tx_data;
      held_sof  = tx_sof;
      held_eof  = tx_eof;
    end
  end

  // ----------------------------------------------------------------------
  // datagram generator and reference model
  // ----------------------------------------------------------------------

  task automatic model_reply(input logic [15:0] src, input logic [15:0] len);
    logic [7:0] hdr [8];
    int         i;
    hdr[0] = local_port[15:8];
    hdr[1] = local_port[7:0];
    hdr[2] = src[15:8];
    hdr[3] = src[7:0];
    hdr[4] = len[15:8];
    hdr[5] = len[7:0];
    hdr[6] = 8'h00;
    hdr[7] = 8'h00;
    for (i = 0; i < 8; i++) begin
      exp_q.push_back({i == 0, (i == 7) && (pay_q.size() == 0), hdr[i]});
    end
    for (i = 0; i < pay_q.size(); i++) begin
      exp_q.push_back({1'b0, i == pay_q.size() - 1, pay_q[i]});
    end
  endtask

  task automatic wait_rx_ready();
    int n;
    n = 0;
    while (!rx_ready) begin
      n++;
      rx_stalls++;
      if (n > RX_TIMEOUT) begin
        fail_now("timeout, rx_ready stayed low too long");
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic drive_frame();
    int i;
    for (i = 0; i < frame_q.size(); i++) begin
      @(negedge clk);
      rx_data  = frame_q[i];
      rx_sof   = (i == 0);
      rx_eof   = (i == frame_q.size() - 1);
      rx_valid = 1'b1;
      wait_rx_ready();
    end
  endtask

  task automatic rx_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      rx_valid = 1'b0;
      rx_sof   = 1'b0;
      rx_eof   = 1'b0;
      rx_data  = 8'h00;
    end
  endtask

  task automatic send_datagram(input int kind, input int pay_len);
    logic [15:0] src;
    logic [15:0] dst;
    logic [15:0] len;
    logic [15:0] cks;
    int          i;
    int          keep;
    src = 16'(rand_range(0, 65535));
    cks = 16'(rand_range(0, 65535));
    dst = local_port;
    len = 16'(`UDP_HDR_LEN + pay_len);
    pay_q.delete();
    for (i = 0; i < pay_len; i++) begin
      pay_q.push_back(8'(rand_range(0, 255)));
    end
    case (kind)
      KIND_BAD_PORT: dst = local_port ^ (16'(rand_range(0, 65535)) | 16'h0001);
      KIND_BAD_LEN: begin
        if (rand_range(0, 1) == 1) begin
          len = len + 16'(rand_range(1, 6));
        end else begin
          len = len - 16'(rand_range(1, 6));
        end
      end
      KIND_OVER_LEN: len = 16'(`UDP_HDR_LEN + `UDP_FIFO_DEPTH + rand_range(1, 500));
      default: begin
      end
    endcase
    frame_q = '{src[15:8], src[7:0], dst[15:8], dst[7:0],
                len[15:8], len[7:0], cks[15:8], cks[7:0]};
    for (i = 0; i < pay_len; i++) begin
      frame_q.push_back(pay_q[i]);
    end
    if (kind == KIND_SHORT) begin
      keep = rand_range(1, `UDP_HDR_LEN - 1);
      while (frame_q.size() > keep) begin
        void'(frame_q.pop_back());
      end
    end
    if (kind == KIND_GOOD) begin
      model_reply(src, len);
    end else begin
      drop_exp = drop_exp + 16'd1;
    end
    drive_frame();
  endtask

  function automatic int pick_kind();
    int roll;
    roll = rand_range(0, 99);
    if (roll < 60) return KIND_GOOD;
    if (roll < 72) return KIND_BAD_PORT;
    if (roll < 84) return KIND_BAD_LEN;
    if (roll < 92) return KIND_OVER_LEN;
    return KIND_SHORT;
  endfunction

  task automatic wait_replies();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n > REPLY_TIMEOUT) begin
        fail_now("timeout, expected replies never came out on tx");
      end else begin
        @(negedge clk);
      end
    end
  endtask

  // drop_count moves two cycles after the eof beat
  task automatic wait_drops();
    int n;
    n = 0;
    while (drop_count !== drop_exp && n < DROP_TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    check_value("drop_count", 32'(drop_count), 32'(drop_exp));
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    clk        = 1'b0;
    fsm_rst    = 1'b1;
    local_port = 16'h0fa1;
    rx_data    = 8'h00;
    rx_valid   = 1'b0;
    rx_sof     = 1'b0;
    rx_eof     = 1'b0;
    tx_ready   = 1'b1;
    stall_pct  = 0;
    rx_stalls  = 0;
    drop_exp   = 16'd0;
    repeat (10) @(negedge clk);
    fsm_rst = 1'b0;
    check_value("tx_valid", 32'(tx_valid), 32'd0);
    check_value("rx_ready", 32'(rx_ready), 32'd1);
    check_value("drop_count", 32'(drop_count), 32'd0);

    // each kind once with its reply or drop awaited before the next
    send_datagram(KIND_GOOD, 5);
    rx_idle(1);
    wait_replies();
    send_datagram(KIND_GOOD, 0);
    rx_idle(1);
    wait_replies();
    send_datagram(KIND_BAD_PORT, 7);
    rx_idle(1);
    wait_drops();
    send_datagram(KIND_BAD_LEN, 12);
    rx_idle(1);
    wait_drops();
    send_datagram(KIND_OVER_LEN, 3);
    rx_idle(1);
    wait_drops();
    send_datagram(KIND_SHORT, 0);
    rx_idle(1);
    wait_drops();

    // mixed traffic with random gaps and tx back-pressure
    stall_pct = 30;
    repeat (80) begin
      send_datagram(pick_kind(), rand_range(0, 40));
      rx_idle(rand_range(0, 3));
    end
    rx_idle(1);
    wait_replies();
    wait_drops();

    // back-to-back burst against a slow reader fills the metadata queue
    stall_pct = 75;
    rx_stalls = 0;
    repeat (40) begin
      send_datagram(pick_kind(), rand_range(0, 40));
    end
    rx_idle(1);
    if (rx_stalls == 0) begin
      fail_now("rx_ready never went low during the burst");
    end
    wait_replies();
    wait_drops();

    // no reply may start once every expected one is out
    rx_idle(20);
    check_value("tx_valid", 32'(tx_valid), 32'd0);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- udp_echo_top.f
+incdir+common
common/udp_pkg.sv
common/udp_payload_if.sv
udp_rx/udp_rx_parser.sv
design/udp_payload_fifo.sv
udp_tx/udp_tx_framer.sv
design/udp_echo_top.sv
bench/udp_echo_tb.sv

//--- run.sh
#!/bin/sh
# build the UDP echo testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
  --top-module udp_echo_tb -f udp_echo_top.f -o udp_echo_sim \
  && ./obj_dir/udp_echo_sim \
  || { echo "simulation run failed"; exit 1; }
